// ==== common/wiscCore_config.svh ====
// Depths are word counts and must be powers of two; reset PC must be even and inside the program
`ifndef WISC_CORE_CONFIG_SVH
`define WISC_CORE_CONFIG_SVH

// Instruction memory, 16-bit words, filled through the load port
`define WISC_IMEM_DEPTH 256

// Data memory, 16-bit words, byte address bit 0 ignored
`define WISC_DMEM_DEPTH 256

// First fetch address after arstN
`define WISC_RESET_PC 16'h0000

`endif

// ==== common/wiscPkg.sv ====
// Types only; opcode values follow the 16-bit WISC encoding, SIIC and RTI are decoded as NOP
package wiscPkg;

    typedef logic [15:0] wordT; // Data word and byte address

    typedef enum logic [4:0] {
        opHalt   = 5'b00000, opNop   = 5'b00001, opSiic  = 5'b00010, opRti   = 5'b00011,
        opJ      = 5'b00100, opJr    = 5'b00101, opJal   = 5'b00110, opJalr  = 5'b00111,
        opAddi   = 5'b01000, opSubi  = 5'b01001, opXori  = 5'b01010, opAndni = 5'b01011,
        opBeqz   = 5'b01100, opBnez  = 5'b01101, opBltz  = 5'b01110, opBgez  = 5'b01111,
        opSt     = 5'b10000, opLd    = 5'b10001, opSlbi  = 5'b10010, opStu   = 5'b10011,
        opRoli   = 5'b10100, opSlli  = 5'b10101, opRori  = 5'b10110, opSrli  = 5'b10111,
        opLbi    = 5'b11000, opBtr   = 5'b11001, opShiftR = 5'b11010, opAluR = 5'b11011,
        opSeq    = 5'b11100, opSlt   = 5'b11101, opSle   = 5'b11110, opSco   = 5'b11111
    } opcodeT;

    typedef struct packed { // R format, func picks the op inside 11010 and 11011
        opcodeT     op;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [1:0] func;
    } rFmtT;

    typedef struct packed { // I format 1, also loads and stores
        opcodeT     op;
        logic [2:0] rs;
        logic [2:0] rd;
        logic [4:0] imm5;
    } i1FmtT;

    typedef struct packed { // I format 2, branches, LBI, SLBI, JR, JALR
        opcodeT     op;
        logic [2:0] rs;
        logic [7:0] imm8;
    } i2FmtT;

    typedef struct packed { // J and JAL
        opcodeT      op;
        logic [10:0] disp11;
    } jFmtT;

    typedef union packed { // Same fetched word, four field layouts
        rFmtT  r;
        i1FmtT i1;
        i2FmtT i2;
        jFmtT  j;
    } instrU;

    typedef enum logic [4:0] {
        aluAdd, aluSub, aluRsub, aluXor, aluAndn, aluSll, aluSrl, aluRol,
        aluRor, aluSeq, aluSlt, aluSle, aluSco, aluBtr, aluPassB, aluSlbi
    } aluOpT;

    typedef enum logic [1:0] {immZero5, immSign5, immSign8, immSign11} immSelT;

    typedef enum logic [1:0] {destRs, destRdI1, destR7, destRdR} destSelT;

    typedef struct packed {
        logic    regWrite; // Register file write
        logic    pcSel;    // Take branchTarget
        logic    pc2Reg;   // Write back PC+2 (link)
        logic    memRead;  // Write back memory data
        logic    memWrite; // Store
        logic    val2Reg;  // Write back ALU result
        logic    immExt;   // Operand B is the immediate, store data from I1 rd
        logic    halt;
        immSelT  immSel;
        destSelT destSel;
        aluOpT   aluOp;
        logic    jumpReg;  // Target base is Rs instead of PC+2
    } ctrlT;

endpackage

// ==== rtl/control.sv ====
// Purely combinational; SIIC, RTI and NOP give an all-zero word, unknown opcodes cannot occur
`timescale 1ns/1ns

module control (
    input  wiscPkg::instrU instr,
    input  logic           zeroFlag,
    input  logic           signFlag,
    output wiscPkg::ctrlT  ctrl
);
    import wiscPkg::*;

    logic [4:0] op; // Opcode bits for group matching
    logic [1:0] func;

    assign op   = instr.r.op;
    assign func = instr.r.func;

    always_comb begin
        ctrl = '0; // Inactive word, also HALT/NOP/SIIC/RTI base
        casez (op)
            5'b000??: begin
                ctrl.halt = (op == opHalt); // Only HALT does anything here
            end
            5'b010??, 5'b101??: begin // I1 arithmetic and shift immediates
                ctrl.regWrite = 1'b1;
                ctrl.val2Reg  = 1'b1;
                ctrl.immExt   = 1'b1;
                ctrl.destSel  = destRdI1;
                ctrl.immSel   = op[1] ? immZero5 : immSign5; // XORI/ANDNI zero extend
                case ({op[3], op[1:0]})
                    3'b100:  ctrl.aluOp = aluAdd;  // ADDI
                    3'b101:  ctrl.aluOp = aluRsub; // SUBI is imm minus Rs
                    3'b110:  ctrl.aluOp = aluXor;
                    3'b111:  ctrl.aluOp = aluAndn;
                    3'b000:  ctrl.aluOp = aluRol;
                    3'b001:  ctrl.aluOp = aluSll;
                    3'b010:  ctrl.aluOp = aluRor;
                    default: ctrl.aluOp = aluSrl;
                endcase
            end
            5'b100??: begin // ST, LD, SLBI, STU
                ctrl.immExt = 1'b1;
                ctrl.immSel = immSign5;   // Effective address offset
                ctrl.aluOp  = aluAdd;     // Rs + imm
                case (op[1:0])
                    2'b00: begin
                        ctrl.memWrite = 1'b1; // ST, no register write
                    end
                    2'b01: begin
                        ctrl.regWrite = 1'b1; // LD into I1 rd
                        ctrl.memRead  = 1'b1;
                        ctrl.destSel  = destRdI1;
                    end
                    2'b10: begin
                        ctrl.regWrite = 1'b1; // SLBI back into Rs
                        ctrl.val2Reg  = 1'b1;
                        ctrl.destSel  = destRs;
                        ctrl.aluOp    = aluSlbi;
                    end
                    default: begin
                        ctrl.regWrite = 1'b1; // STU, address back into Rs
                        ctrl.memWrite = 1'b1;
                        ctrl.val2Reg  = 1'b1;
                        ctrl.destSel  = destRs;
                    end
                endcase
            end
            5'b011??: begin // Branches on Rs flags
                ctrl.immSel = immSign8;
                case (op[1:0])
                    2'b00:   ctrl.pcSel = zeroFlag;  // BEQZ
                    2'b01:   ctrl.pcSel = ~zeroFlag; // BNEZ
                    2'b10:   ctrl.pcSel = signFlag;  // BLTZ
                    default: ctrl.pcSel = ~signFlag; // BGEZ
                endcase
            end
            5'b001??: begin // J, JR, JAL, JALR
                ctrl.pcSel   = 1'b1;
                ctrl.jumpReg = op[0];                      // JR/JALR use Rs base
                ctrl.immSel  = op[0] ? immSign8 : immSign11;
                if (op[1]) begin                           // Link variants
                    ctrl.regWrite = 1'b1;
                    ctrl.pc2Reg   = 1'b1;
                    ctrl.destSel  = destR7;
                end
            end
            opLbi: begin
                ctrl.regWrite = 1'b1;
                ctrl.val2Reg  = 1'b1;
                ctrl.immExt   = 1'b1;
                ctrl.immSel   = immSign8;
                ctrl.destSel  = destRs;
                ctrl.aluOp    = aluPassB; // Rs <- sign extended imm8
            end
            default: begin // R format, BTR through SCO
                ctrl.regWrite = 1'b1;
                ctrl.val2Reg  = 1'b1;
                ctrl.destSel  = destRdR;
                casez ({op, func})
                    {opBtr, 2'b??}:    ctrl.aluOp = aluBtr;
                    {opShiftR, 2'b00}: ctrl.aluOp = aluRol;
                    {opShiftR, 2'b01}: ctrl.aluOp = aluSll;
                    {opShiftR, 2'b10}: ctrl.aluOp = aluRor;
                    {opShiftR, 2'b11}: ctrl.aluOp = aluSrl;
                    {opAluR, 2'b00}:   ctrl.aluOp = aluAdd;
                    {opAluR, 2'b01}:   ctrl.aluOp = aluSub;
                    {opAluR, 2'b10}:   ctrl.aluOp = aluXor;
                    {opAluR, 2'b11}:   ctrl.aluOp = aluAndn;
                    {opSeq, 2'b??}:    ctrl.aluOp = aluSeq;
                    {opSlt, 2'b??}:    ctrl.aluOp = aluSlt;
                    {opSle, 2'b??}:    ctrl.aluOp = aluSle;
                    default:           ctrl.aluOp = aluSco;
                endcase
            end
        endcase
    end

endmodule

// ==== rtl/regFile.sv ====
// No write-to-read bypass; a same-cycle read returns the old value, R0 is an ordinary register
`timescale 1ns/1ns

module regFile (
    input  logic          clk,
    input  logic          arstN,
    input  logic [2:0]    rdAddrA,
    input  logic [2:0]    rdAddrB,
    output wiscPkg::wordT rdDataA,
    output wiscPkg::wordT rdDataB,
    input  logic          wrEn,
    input  logic [2:0]    wrAddr,
    input  wiscPkg::wordT wrData
);
    import wiscPkg::*;

    wordT regs [8]; // R0..R7

    assign rdDataA = regs[rdAddrA]; // Rs port
    assign rdDataB = regs[rdAddrB]; // Rt or store data port

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0; // Architectural state starts at zero
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

// ==== rtl/instrFetch.sv ====
// Program loads only while run is low; PC must stay even, odd jump targets are a program error
`timescale 1ns/1ns
`include "wiscCore_config.svh"

module instrFetch (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                run,
    input  logic                                haltReq,
    input  logic                                pcSel,
    input  wiscPkg::wordT                       branchTarget,
    input  logic                                progWrEn,
    input  logic [$clog2(`WISC_IMEM_DEPTH)-1:0] progAddr,
    input  wiscPkg::wordT                       progData,
    output wiscPkg::instrU                      instr,
    output wiscPkg::wordT                       pc,
    output wiscPkg::wordT                       pcPlus2,
    output logic                                halted
);
    import wiscPkg::*;

    localparam int ImemAw = $clog2(`WISC_IMEM_DEPTH);

    wordT imem [`WISC_IMEM_DEPTH]; // Program store, no reset
    logic step;                    // Instruction retires this cycle

    assign step    = run & ~halted;
    assign pcPlus2 = pc + 16'd2;
    assign instr   = imem[pc[ImemAw:1]]; // Word index from byte PC

    // Load port, ignored once the core runs
    always_ff @(posedge clk) begin
        if (progWrEn && !run) begin
            imem[progAddr] <= progData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc     <= `WISC_RESET_PC;
            halted <= 1'b0;
        end else if (step) begin
            if (haltReq) begin
                halted <= 1'b1;                          // Sticky until reset, PC holds
            end else begin
                pc <= pcSel ? branchTarget : pcPlus2;    // Taken branch or jump
            end
        end
    end

    // Target arithmetic from execUnit and the program must keep fetches aligned
    pcEven: assert property (@(posedge clk) disable iff (!arstN) step |=> !pc[0])
        else $error("instrFetch: odd PC %h", pc);

endmodule

// ==== rtl/dataMem.sv ====
// Word addressed from addr bits above bit 0; no alignment check, high address bits are dropped
`timescale 1ns/1ns
`include "wiscCore_config.svh"

module dataMem (
    input  logic          clk,
    input  wiscPkg::wordT addr,
    input  wiscPkg::wordT wrData,
    input  logic          wrEn,
    output wiscPkg::wordT rdData
);
    import wiscPkg::*;

    localparam int DmemAw = $clog2(`WISC_DMEM_DEPTH);

    wordT mem [`WISC_DMEM_DEPTH]; // Contents undefined until written
    logic [DmemAw-1:0] wordIdx;

    assign wordIdx = addr[DmemAw:1]; // Byte address to word index

    // Read is combinational, LD data is valid in the same cycle
    assign rdData = mem[wordIdx];

    always_ff @(posedge clk) begin
        if (wrEn) begin // Caller gates with run and not halted
            mem[wordIdx] <= wrData;
        end
    end

endmodule

// ==== execute/execUnit.sv ====
// Combinational; shift and rotate amounts use the low four bits of operand B, flags describe Rs
`timescale 1ns/1ns

module execUnit (
    input  wiscPkg::instrU instr,
    input  wiscPkg::ctrlT  ctrl,
    input  wiscPkg::wordT  rsData,
    input  wiscPkg::wordT  rtData,
    input  wiscPkg::wordT  pcPlus2,
    output wiscPkg::wordT  aluResult,
    output wiscPkg::wordT  branchTarget,
    output logic           zeroFlag,
    output logic           signFlag
);
    import wiscPkg::*;

    wordT        imm;     // Extended immediate
    wordT        opB;     // Second ALU operand
    logic [3:0]  amt;     // Shift or rotate amount
    logic [16:0] sum;     // Rs + B with carry
    logic [31:0] rolWide;
    logic [31:0] rorWide;
    wordT        rev;     // Bit reversed Rs

    // Immediate extension by format
    always_comb begin
        case (ctrl.immSel)
            immZero5: imm = {11'b0, instr.i1.imm5};
            immSign5: imm = {{11{instr.i1.imm5[4]}}, instr.i1.imm5};
            immSign8: imm = {{8{instr.i2.imm8[7]}}, instr.i2.imm8};
            default:  imm = {{5{instr.j.disp11[10]}}, instr.j.disp11};
        endcase
    end

    assign opB = ctrl.immExt ? imm : rtData;
    assign amt = opB[3:0];
    assign sum = {1'b0, rsData} + {1'b0, opB};

    assign rolWide = {rsData, rsData} << amt; // Upper half holds the rotate
    assign rorWide = {rsData, rsData} >> amt; // Lower half holds the rotate
    assign rev     = {<<{rsData}};

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:   aluResult = sum[15:0];               // Also effective address
            aluSub:   aluResult = rsData - opB;
            aluRsub:  aluResult = opB - rsData;            // SUBI
            aluXor:   aluResult = rsData ^ opB;
            aluAndn:  aluResult = rsData & ~opB;
            aluSll:   aluResult = rsData << amt;
            aluSrl:   aluResult = rsData >> amt;
            aluRol:   aluResult = rolWide[31:16];
            aluRor:   aluResult = rorWide[15:0];
            aluSeq:   aluResult = {15'b0, rsData == opB};
            aluSlt:   aluResult = {15'b0, $signed(rsData) < $signed(opB)};
            aluSle:   aluResult = {15'b0, $signed(rsData) <= $signed(opB)};
            aluSco:   aluResult = {15'b0, sum[16]};        // Unsigned carry out
            aluBtr:   aluResult = rev;
            aluPassB: aluResult = opB;                     // LBI
            aluSlbi:  aluResult = {rsData[7:0], instr.i2.imm8}; // imm8 zero extended
            default:  aluResult = sum[15:0];
        endcase
    end

    // PC relative for branches and J/JAL, register based for JR/JALR
    assign branchTarget = (ctrl.jumpReg ? rsData : pcPlus2) + imm;

    assign zeroFlag = (rsData == '0);
    assign signFlag = rsData[15];

endmodule

// ==== rtl/wiscCore.sv ====
// Single cycle, no exceptions or caches; load the program with run low, commit ports are combinational
`timescale 1ns/1ns
`include "wiscCore_config.svh"

module wiscCore (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                run,
    input  logic                                progWrEn,
    input  logic [$clog2(`WISC_IMEM_DEPTH)-1:0] progAddr,
    input  wiscPkg::wordT                       progData,
    output logic                                halted,
    output logic                                commitValid,
    output wiscPkg::wordT                       commitPc,
    output logic                                commitWrEn,
    output logic [2:0]                          commitWrReg,
    output wiscPkg::wordT                       commitWrData
);
    import wiscPkg::*;

    instrU      instr;
    ctrlT       ctrl;
    wordT       pc, pcPlus2, rsData, rtData, aluResult, branchTarget, memData, wbData;
    logic       zeroFlag, signFlag;
    logic       active;   // An instruction retires this cycle
    logic       regWrEn;
    logic       memWrEn;
    logic [2:0] rdAddrB;  // Rt, also ST/STU data
    logic [2:0] wrReg;

    assign active  = run & ~halted;
    assign regWrEn = ctrl.regWrite & active;
    assign memWrEn = ctrl.memWrite & active;
    assign rdAddrB = instr.r.rt; // I1 rd of ST/STU sits in the same bits as Rt

    // Write back source, link has priority
    assign wbData = ctrl.pc2Reg ? pcPlus2 : (ctrl.memRead ? memData : aluResult);

    always_comb begin
        case (ctrl.destSel)
            destRs:   wrReg = instr.r.rs;  // LBI, SLBI, STU
            destRdI1: wrReg = instr.i1.rd;
            destR7:   wrReg = 3'd7;        // JAL, JALR link
            default:  wrReg = instr.r.rd;
        endcase
    end

    instrFetch uFetch (
        .clk, .arstN, .run, .haltReq(ctrl.halt), .pcSel(ctrl.pcSel), .branchTarget,
        .progWrEn, .progAddr, .progData, .instr, .pc, .pcPlus2, .halted
    );

    control uControl (.instr, .zeroFlag, .signFlag, .ctrl);

    regFile uRegs (
        .clk, .arstN, .rdAddrA(instr.r.rs), .rdAddrB, .rdDataA(rsData), .rdDataB(rtData),
        .wrEn(regWrEn), .wrAddr(wrReg), .wrData(wbData)
    );

    execUnit uExec (
        .instr, .ctrl, .rsData, .rtData, .pcPlus2, .aluResult, .branchTarget,
        .zeroFlag, .signFlag
    );

    dataMem uDmem (.clk, .addr(aluResult), .wrData(rtData), .wrEn(memWrEn), .rdData(memData));

    assign commitValid  = active;
    assign commitPc     = pc;
    assign commitWrEn   = regWrEn;
    assign commitWrReg  = wrReg;
    assign commitWrData = wbData;

    // Control word never asks memory for a load and a store together
    memRdWr: assert property (@(posedge clk) disable iff (!arstN)
        active |-> !(ctrl.memRead && ctrl.memWrite))
        else $error("wiscCore: memRead and memWrite both set");

    // Every register write has exactly one value source
    wbOneSrc: assert property (@(posedge clk) disable iff (!arstN)
        regWrEn |-> $onehot({ctrl.pc2Reg, ctrl.memRead, ctrl.val2Reg}))
        else $error("wiscCore: ambiguous write-back source");

endmodule

// ==== sim/wiscCoreTb.sv ====
// Absolute jump targets assume reset PC 0; unused program words hold HALTs tagged with their address
`timescale 1ns/1ns
`include "wiscCore_config.svh"

module wiscCoreTb;
    import wiscPkg::*;

    typedef struct packed {
        wordT       pc;
        logic       wrEn;
        logic [2:0] wrReg;
        wordT       wrData;
    } commitT;

    localparam int ImemAw = $clog2(`WISC_IMEM_DEPTH);

    logic              clk;
    logic              arstN;
    logic              run;
    logic              progWrEn;
    logic [ImemAw-1:0] progAddr;
    wordT              progData;
    logic              halted;
    logic              commitValid;
    logic              commitWrEn;
    wordT              commitPc;
    wordT              commitWrData;
    logic [2:0]        commitWrReg;

    wordT   prog [`WISC_IMEM_DEPTH]; // Image for the next run
    commitT expQ [$];                // Commits the ISA rules predict
    commitT gotQ [$];                // Commits seen on the trace ports
    wordT   curPc;                   // Byte address of the next placed instruction
    int     errors;

    wiscCore DUT (
        .clk, .arstN, .run, .progWrEn, .progAddr, .progData, .halted,
        .commitValid, .commitPc, .commitWrEn, .commitWrReg, .commitWrData
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    function automatic wordT rFormat(logic [4:0] op, logic [2:0] rs, logic [2:0] rt,
                                     logic [2:0] rd, logic [1:0] fn);
        return {op, rs, rt, rd, fn};
    endfunction

    function automatic wordT i1Format(logic [4:0] op, logic [2:0] rs, logic [2:0] rd,
                                      logic [4:0] imm5);
        return {op, rs, rd, imm5};
    endfunction

    function automatic wordT i2Format(logic [4:0] op, logic [2:0] rs, logic [7:0] imm8);
        return {op, rs, imm8};
    endfunction

    function automatic wordT jFormat(logic [4:0] op, logic [10:0] disp11);
        return {op, disp11};
    endfunction

    function automatic wordT rotLeft(wordT x, logic [3:0] n);
        return (x << n) | (x >> (5'd16 - {1'b0, n})); // Shift by 16 gives zero
    endfunction

    function automatic wordT rotRight(wordT x, logic [3:0] n);
        return (x >> n) | (x << (5'd16 - {1'b0, n}));
    endfunction

    function automatic wordT bitReverse(wordT x);
        wordT r;
        for (int i = 0; i < 16; i++) begin
            r[i] = x[15 - i];
        end
        return r;
    endfunction

    task automatic newProgram();
        for (int i = 0; i < `WISC_IMEM_DEPTH; i++) begin
            prog[i] = {5'b00000, 11'(i)}; // HALT opcode, low bits carry the word address
        end
        expQ.delete();
        curPc = `WISC_RESET_PC;
    endtask

    task automatic placeJump(input wordT word, input logic wrEn, input logic [2:0] wrReg,
                             input wordT wrData, input wordT nextPc);
        prog[curPc[ImemAw:1]] = word;
        expQ.push_back({curPc, wrEn, wrReg, wrData});
        curPc = nextPc; // Where the following instruction is expected
    endtask

    task automatic placeInstr(input wordT word, input logic wrEn, input logic [2:0] wrReg,
                              input wordT wrData);
        placeJump(word, wrEn, wrReg, wrData, curPc + 16'd2);
    endtask

    task automatic resetCore();
        @(posedge clk);
        #2;
        arstN = 1'b0;
        run   = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        arstN = 1'b1;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < `WISC_IMEM_DEPTH; i++) begin
            @(posedge clk);
            #2;
            progWrEn = 1'b1;
            progAddr = ImemAw'(i);
            progData = prog[i];
        end
        @(posedge clk);
        #2;
        progWrEn = 1'b0;
        run      = 1'b1; // Fetch starts at the next edge
    endtask

    task automatic collectCommits();
        int     cycles;
        commitT c;
        gotQ.delete();
        cycles = 0;
        while (!halted && cycles < 300) begin
            @(negedge clk); // Trace ports settled mid cycle
            if (commitValid && !halted) begin
                c = {commitPc, commitWrEn, commitWrReg, commitWrData};
                gotQ.push_back(c);
            end
            cycles++;
        end
        if (!halted) begin
            errors++;
            $display("Timeout at %0t: core did not halt within 300 cycles", $time);
        end
    endtask

    task automatic compareTrace(input string name);
        int n;
        n = (gotQ.size() < expQ.size()) ? gotQ.size() : expQ.size();
        if (gotQ.size() != expQ.size()) begin
            errors++;
            $display("FAIL %0t %s commit count expected %0d got %0d",
                     $time, name, expQ.size(), gotQ.size());
        end
        for (int i = 0; i < n; i++) begin
            if (gotQ[i].pc !== expQ[i].pc) begin
                errors++;
                $display("FAIL %0t %s commitPc[%0d] expected %h got %h",
                         $time, name, i, expQ[i].pc, gotQ[i].pc);
            end
            if (gotQ[i].wrEn !== expQ[i].wrEn) begin
                errors++;
                $display("FAIL %0t %s commitWrEn[%0d] expected %b got %b",
                         $time, name, i, expQ[i].wrEn, gotQ[i].wrEn);
            end
            if (expQ[i].wrEn && gotQ[i].wrReg !== expQ[i].wrReg) begin
                errors++;
                $display("FAIL %0t %s commitWrReg[%0d] expected %0d got %0d",
                         $time, name, i, expQ[i].wrReg, gotQ[i].wrReg);
            end
            if (expQ[i].wrEn && gotQ[i].wrData !== expQ[i].wrData) begin
                errors++;
                $display("FAIL %0t %s commitWrData[%0d] expected %h got %h",
                         $time, name, i, expQ[i].wrData, gotQ[i].wrData);
            end
        end
    endtask

    task automatic runProgram(input string name);
        resetCore();
        loadProgram();
        collectCommits();
        compareTrace(name);
    endtask

    task automatic arithLogicOps();
        wordT        a;
        wordT        b;
        logic [4:0]  i5;
        logic [3:0]  s;
        logic [3:0]  k;
        logic [16:0] sum;
        wordT        sx5;
        wordT        zx5;
        a   = 16'($urandom);
        b   = 16'($urandom);
        i5  = 5'($urandom) | 5'h10; // Negative imm5 separates sign and zero extension
        s   = b[3:0];               // Register shift amount
        k   = i5[3:0];              // Immediate shift amount
        sum = {1'b0, a} + {1'b0, b};
        sx5 = {{11{i5[4]}}, i5};
        zx5 = {11'b0, i5};
        newProgram();
        placeInstr(i2Format(opLbi, 3'd1, a[15:8]), 1'b1, 3'd1, {{8{a[15]}}, a[15:8]});
        placeInstr(i2Format(opSlbi, 3'd1, a[7:0]), 1'b1, 3'd1, a);
        placeInstr(i2Format(opLbi, 3'd2, b[15:8]), 1'b1, 3'd2, {{8{b[15]}}, b[15:8]});
        placeInstr(i2Format(opSlbi, 3'd2, b[7:0]), 1'b1, 3'd2, b);
        placeInstr(rFormat(opAluR, 3'd1, 3'd2, 3'd3, 2'b00), 1'b1, 3'd3, a + b);
        placeInstr(rFormat(opAluR, 3'd1, 3'd2, 3'd3, 2'b01), 1'b1, 3'd3, a - b);
        placeInstr(rFormat(opAluR, 3'd1, 3'd2, 3'd3, 2'b10), 1'b1, 3'd3, a ^ b);
        placeInstr(rFormat(opAluR, 3'd1, 3'd2, 3'd3, 2'b11), 1'b1, 3'd3, a & ~b);
        placeInstr(rFormat(opShiftR, 3'd1, 3'd2, 3'd4, 2'b00), 1'b1, 3'd4, rotLeft(a, s));
        placeInstr(rFormat(opShiftR, 3'd1, 3'd2, 3'd4, 2'b01), 1'b1, 3'd4, a << s);
        placeInstr(rFormat(opShiftR, 3'd1, 3'd2, 3'd4, 2'b10), 1'b1, 3'd4, rotRight(a, s));
        placeInstr(rFormat(opShiftR, 3'd1, 3'd2, 3'd4, 2'b11), 1'b1, 3'd4, a >> s);
        placeInstr(rFormat(opBtr, 3'd1, 3'd0, 3'd5, 2'b00), 1'b1, 3'd5, bitReverse(a));
        placeInstr(rFormat(opSeq, 3'd1, 3'd1, 3'd5, 2'b00), 1'b1, 3'd5, 16'd1);
        placeInstr(rFormat(opSeq, 3'd1, 3'd2, 3'd5, 2'b00), 1'b1, 3'd5, {15'b0, a == b});
        placeInstr(rFormat(opSlt, 3'd1, 3'd2, 3'd5, 2'b00), 1'b1, 3'd5,
                   {15'b0, $signed(a) < $signed(b)});
        placeInstr(rFormat(opSle, 3'd2, 3'd1, 3'd5, 2'b00), 1'b1, 3'd5,
                   {15'b0, $signed(b) <= $signed(a)});
        placeInstr(rFormat(opSco, 3'd1, 3'd2, 3'd5, 2'b00), 1'b1, 3'd5, {15'b0, sum[16]});
        placeInstr(i1Format(opAddi, 3'd1, 3'd6, i5), 1'b1, 3'd6, a + sx5);
        placeInstr(i1Format(opSubi, 3'd1, 3'd6, i5), 1'b1, 3'd6, sx5 - a); // Imm minus Rs
        placeInstr(i1Format(opXori, 3'd1, 3'd6, i5), 1'b1, 3'd6, a ^ zx5);
        placeInstr(i1Format(opAndni, 3'd1, 3'd6, i5), 1'b1, 3'd6, a & ~zx5);
        placeInstr(i1Format(opRoli, 3'd1, 3'd7, i5), 1'b1, 3'd7, rotLeft(a, k));
        placeInstr(i1Format(opSlli, 3'd1, 3'd7, i5), 1'b1, 3'd7, a << k);
        placeInstr(i1Format(opRori, 3'd1, 3'd7, i5), 1'b1, 3'd7, rotRight(a, k));
        placeInstr(i1Format(opSrli, 3'd1, 3'd7, i5), 1'b1, 3'd7, a >> k);
        placeInstr(jFormat(opHalt, 11'd0), 1'b0, 3'd0, 16'd0);
        runProgram("arith");
    endtask

    task automatic memoryAccess();
        wordT a;
        a = 16'($urandom);
        newProgram();
        placeInstr(i2Format(opLbi, 3'd1, 8'h20), 1'b1, 3'd1, 16'h0020); // Base address
        placeInstr(i2Format(opLbi, 3'd2, a[15:8]), 1'b1, 3'd2, {{8{a[15]}}, a[15:8]});
        placeInstr(i2Format(opSlbi, 3'd2, a[7:0]), 1'b1, 3'd2, a);
        placeInstr(i1Format(opSt, 3'd1, 3'd2, 5'd4), 1'b0, 3'd0, 16'd0);    // mem[0x24] = a
        placeInstr(i1Format(opLd, 3'd1, 3'd3, 5'd4), 1'b1, 3'd3, a);
        placeInstr(i1Format(opStu, 3'd1, 3'd1, 5'h1e), 1'b1, 3'd1, 16'h001e); // Stores old R1
        placeInstr(i1Format(opLd, 3'd1, 3'd4, 5'd0), 1'b1, 3'd4, 16'h0020);
        placeInstr(jFormat(opHalt, 11'd0), 1'b0, 3'd0, 16'd0);
        runProgram("memory");
    endtask

    task automatic branchConditions();
        newProgram();
        placeInstr(i2Format(opLbi, 3'd2, 8'h80), 1'b1, 3'd2, 16'hff80); // Negative, R1 stays 0
        placeInstr(i2Format(opLbi, 3'd3, 8'h05), 1'b1, 3'd3, 16'h0005); // Positive
        placeJump(i2Format(opBeqz, 3'd1, 8'd4), 1'b0, 3'd0, 16'd0, curPc + 16'd6);
        placeInstr(i2Format(opBeqz, 3'd3, 8'd4), 1'b0, 3'd0, 16'd0);
        placeJump(i2Format(opBnez, 3'd3, 8'd6), 1'b0, 3'd0, 16'd0, curPc + 16'd8);
        placeInstr(i2Format(opBnez, 3'd1, 8'd4), 1'b0, 3'd0, 16'd0);
        placeJump(i2Format(opBltz, 3'd2, 8'd2), 1'b0, 3'd0, 16'd0, curPc + 16'd4);
        placeInstr(i2Format(opBltz, 3'd3, 8'd4), 1'b0, 3'd0, 16'd0);
        placeJump(i2Format(opBgez, 3'd3, 8'd4), 1'b0, 3'd0, 16'd0, curPc + 16'd6);
        placeInstr(i2Format(opBgez, 3'd2, 8'd4), 1'b0, 3'd0, 16'd0);
        placeInstr(jFormat(opHalt, 11'd0), 1'b0, 3'd0, 16'd0);
        runProgram("branch");
    endtask

    task automatic jumpTargets();
        newProgram();
        placeJump(jFormat(opJ, 11'd6), 1'b0, 3'd0, 16'd0, curPc + 16'd8);            // 0 to 8
        placeJump(jFormat(opJal, 11'd4), 1'b1, 3'd7, curPc + 16'd2, curPc + 16'd6);  // 8 to 14
        placeInstr(i2Format(opLbi, 3'd1, 8'd60), 1'b1, 3'd1, 16'd60);
        placeJump(i2Format(opJr, 3'd1, 8'd4), 1'b0, 3'd0, 16'd0, 16'd64);
        placeJump(i2Format(opJalr, 3'd1, 8'hfc), 1'b1, 3'd7, curPc + 16'd2, 16'd56); // Backward
        placeInstr(jFormat(opHalt, 11'd0), 1'b0, 3'd0, 16'd0);
        runProgram("jump");
    endtask

    task automatic haltAndReset();
        newProgram();
        placeInstr(jFormat(opNop, 11'd0), 1'b0, 3'd0, 16'd0);
        placeInstr(jFormat(opSiic, 11'd0), 1'b0, 3'd0, 16'd0);
        placeInstr(jFormat(opRti, 11'd0), 1'b0, 3'd0, 16'd0);
        placeInstr(i2Format(opLbi, 3'd6, 8'h7f), 1'b1, 3'd6, 16'h007f);
        placeInstr(jFormat(opHalt, 11'd0), 1'b0, 3'd0, 16'd0);
        runProgram("halt");
        for (int i = 0; i < 10; i++) begin // Bounded watch after HALT
            @(negedge clk);
            if (!halted || commitValid) begin
                errors++;
                $display("Core left halt or committed after HALT at %0t", $time);
            end
        end
        @(posedge clk);
        #2;
        arstN = 1'b0; // Run stays high, reset alone must clear halt
        @(negedge clk);
        if (halted !== 1'b0) begin
            errors++;
            $display("FAIL %0t halted expected 0 got %b", $time, halted);
        end
        if (commitPc !== `WISC_RESET_PC) begin
            errors++;
            $display("FAIL %0t commitPc expected %h got %h", $time, `WISC_RESET_PC, commitPc);
        end
        @(posedge clk);
        #2;
        run   = 1'b0;
        arstN = 1'b1;
    endtask

    initial begin
        void'($urandom(93172)); // One seed for the whole run
        errors   = 0;
        arstN    = 1'b0;
        run      = 1'b0;
        progWrEn = 1'b0;
        progAddr = '0;
        progData = '0;
        arithLogicOps();
        memoryAccess();
        branchConditions();
        jumpTargets();
        haltAndReset();
        $display("Checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== wiscCore.f ====
+incdir+common
common/wiscPkg.sv
rtl/control.sv
rtl/regFile.sv
rtl/instrFetch.sv
rtl/dataMem.sv
execute/execUnit.sv
rtl/wiscCore.sv
sim/wiscCoreTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = wiscCoreTb
FLIST     = wiscCore.f

.PHONY: sim clean

# Build, run, and pass only if the pass message shows up in the output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null

clean:
	rm -rf obj_dir
